/* Bender.yml */
package:
  name: fetch_stage

export_include_dirs:
  - include

sources:
  - src/fetch_pkg.sv
  - src/fetch_req_if.sv
  - src/fetch_fifo.sv
  - src/bpu.sv
  - src/pc_gen.sv
  - src/fetch_mem_if.sv
  - src/fetch_stage.sv
  - target: test
    files:
      - test/tb_fetch_stage.sv

/* include/fetch_defs.svh */
// Fetch stage sizing macros: widths, BTB index, boot address, memory depth
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Address width in bits
`define FETCH_XLEN 32

// Instruction word width in bits
`define FETCH_ILEN 32

// PC bits above bit 1 that index the BTB (16 entries)
`define FETCH_BTB_BITS 4

// First fetch address after reset
`define FETCH_BOOT_PC 32'h0000_1000

// Max outstanding memory requests, also response buffer depth
`define FETCH_MEM_DEPTH 2

`endif

/* src.f */
+incdir+include
src/fetch_pkg.sv
src/fetch_req_if.sv
src/fetch_fifo.sv
src/bpu.sv
src/pc_gen.sv
src/fetch_mem_if.sv
src/fetch_stage.sv
test/tb_fetch_stage.sv

/* src/bpu.sv */
// Branch predictor: direct-mapped BTB with 2-bit saturating counters
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module bpu (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   flush_i,
  fetch_req_if.bpu               req,
  input  logic                   res_valid_i,
  input  fetch_pkg::resolution_t res_i
);

  localparam int unsigned XLEN    = `FETCH_XLEN;
  localparam int unsigned IDX_W   = `FETCH_BTB_BITS;
  localparam int unsigned ENTRIES = 1 << IDX_W;
  localparam int unsigned TAG_W   = XLEN - IDX_W - 2;

  // BTB arrays, only valid bits are reset
  logic [ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]   tag_q    [ENTRIES];
  logic [XLEN-1:0]    target_q [ENTRIES];
  logic [1:0]         cnt_q    [ENTRIES];

  // --------------------------------------------------
  // Lookup, combinational on the fetch PC
  // --------------------------------------------------
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic             rd_hit;
  logic             rd_taken;

  assign rd_idx   = req.pc[IDX_W+1:2];
  assign rd_tag   = req.pc[XLEN-1:IDX_W+2];
  assign rd_hit   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  // Counter MSB set means 2 or 3, taken
  assign rd_taken = rd_hit && cnt_q[rd_idx][1];

  assign req.pred.pc     = req.pc;
  assign req.pred.taken  = rd_taken;
  assign req.pred.target = rd_taken ? target_q[rd_idx] : req.pc + XLEN'(4);

  // --------------------------------------------------
  // Update from branch resolutions
  // --------------------------------------------------
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_hit;
  logic [1:0]       cnt_base;
  logic [1:0]       cnt_next;

  assign wr_idx   = res_i.pc[IDX_W+1:2];
  assign wr_tag   = res_i.pc[XLEN-1:IDX_W+2];
  assign wr_hit   = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);
  // Miss allocates at the weakly not taken value
  assign cnt_base = wr_hit ? cnt_q[wr_idx] : fetch_pkg::BTB_INIT_CNT;

  // Saturating move toward the outcome
  always_comb begin
    cnt_next = cnt_base;
    if (res_i.taken && cnt_base != 2'b11)       cnt_next = cnt_base + 2'b01;
    else if (!res_i.taken && cnt_base != 2'b00) cnt_next = cnt_base - 2'b01;
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (res_valid_i) begin
      tag_q[wr_idx] <= wr_tag;
      cnt_q[wr_idx] <= cnt_next;
      // Target only known for taken branches
      if (res_i.taken) target_q[wr_idx] <= res_i.target;
    end
  end

  // Valid bits, flush drops the whole table
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (res_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Branch unit sends word-aligned branch addresses
  a_res_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_valid_i |-> res_i.pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* src/fetch_fifo.sv */
// Circular FIFO with a type parameter for the payload and single-cycle clear
`timescale 1ns/100ps
`default_nettype none

module fetch_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       push_i,
  input  logic                       pop_i,
  input  T                           data_i,
  output T                           data_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  // Pointer width, at least one bit
  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                           mem [DEPTH];
  logic [PW-1:0]              wr_ptr_q;
  logic [PW-1:0]              rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  // Wrap at DEPTH, works for any depth
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    ptr_inc = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_i && !full_o) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      // Simultaneous push and pop keeps the count
      if (push_i && !pop_i)      count_q <= count_q + 1'b1;
      else if (pop_i && !push_i) count_q <= count_q - 1'b1;
    end
  end

  assign data_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == ($clog2(DEPTH+1))'(DEPTH));
  assign count_o = count_q;

  // Callers must respect occupancy
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i && !clear_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i && !clear_i |-> !empty_o);

endmodule

`default_nettype wire

/* src/fetch_mem_if.sv */
// Fetch memory interface: credit-based issue, in-order responses, flush discard
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_mem_if (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    flush_i,
  fetch_req_if.memif              req,
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output logic [`FETCH_XLEN-1:0]  instr_addr_o,
  input  logic                    instr_valid_i,
  output logic                    instr_ready_o,
  input  logic [`FETCH_ILEN-1:0]  instr_rdata_i,
  input  logic                    instr_except_raised_i,
  input  fetch_pkg::except_code_t instr_except_code_i,
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i,
  output logic [`FETCH_ILEN-1:0]  issue_instr_o,
  output fetch_pkg::prediction_t  issue_pred_o,
  output logic                    issue_except_raised_o,
  output fetch_pkg::except_code_t issue_except_code_o
);

  localparam int unsigned DEPTH = `FETCH_MEM_DEPTH;
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  // Prediction buffer covers requests in flight plus buffered words
  logic [CW-1:0]        pred_cnt;
  logic [CW-1:0]        resp_cnt;
  logic                 resp_empty;
  logic                 resp_full;
  fetch_pkg::mem_resp_t resp_in;
  fetch_pkg::mem_resp_t resp_out;

  // Flushed requests still owed by memory
  logic [CW-1:0]        discard_q;
  logic [CW:0]          used;
  logic                 credit;
  logic                 req_fire;
  logic                 rsp_fire;
  logic                 rsp_keep;
  logic                 issue_fire;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------
  assign used     = pred_cnt + discard_q;
  assign credit   = used < (CW + 1)'(DEPTH);

  assign instr_valid_o = req.valid && credit && !flush_i;
  assign instr_addr_o  = req.pc;
  assign req.ready     = credit && instr_ready_i && !flush_i;
  assign req_fire      = req.valid && req.ready;

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------
  assign instr_ready_o = !resp_full || (discard_q != '0);
  assign rsp_fire      = instr_valid_i && instr_ready_o;
  // Words owed from before a flush are dropped
  assign rsp_keep      = rsp_fire && (discard_q == '0) && !flush_i;
  assign issue_fire    = issue_valid_o && issue_ready_i;

  assign resp_in.instr         = instr_rdata_i;
  assign resp_in.except_raised = instr_except_raised_i;
  assign resp_in.except_code   = instr_except_code_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      discard_q <= '0;
    end else if (flush_i) begin
      // Everything in flight becomes owed, minus a word landing now
      discard_q <= discard_q + (pred_cnt - resp_cnt) - CW'(rsp_fire);
    end else if (rsp_fire && discard_q != '0) begin
      discard_q <= discard_q - 1'b1;
    end
  end

  // --------------------------------------------------
  // Buffers
  // --------------------------------------------------
  fetch_fifo #(
    .T    (fetch_pkg::prediction_t),
    .DEPTH(DEPTH)
  ) u_pred_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .clear_i (flush_i),
    .push_i  (req_fire),
    .pop_i   (issue_fire),
    .data_i  (req.pred),
    .data_o  (issue_pred_o),
    .empty_o (),
    .full_o  (),
    .count_o (pred_cnt)
  );

  fetch_fifo #(
    .T    (fetch_pkg::mem_resp_t),
    .DEPTH(DEPTH)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .clear_i (flush_i),
    .push_i  (rsp_keep),
    .pop_i   (issue_fire),
    .data_i  (resp_in),
    .data_o  (resp_out),
    .empty_o (resp_empty),
    .full_o  (resp_full),
    .count_o (resp_cnt)
  );

  // Decode side
  assign issue_valid_o         = !resp_empty;
  assign issue_instr_o         = resp_out.instr;
  assign issue_except_raised_o = resp_out.except_raised;
  assign issue_except_code_o   = resp_out.except_code;

  // Memory answers only requests it was given
  a_rsp_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_valid_i |-> (pred_cnt > resp_cnt) || (discard_q != '0));

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
// Fetch stage types: predictions, branch resolutions, exceptions, responses
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // --------------------------------------------------
  // Exceptions
  // --------------------------------------------------
  typedef logic [3:0] except_code_t;

  // Instruction access fault, RISC-V cause 1
  localparam except_code_t E_INSTR_ACCESS_FAULT = 4'h1;

  // --------------------------------------------------
  // Branch prediction
  // --------------------------------------------------
  // Empty BTB entry starts weakly not taken
  localparam logic [1:0] BTB_INIT_CNT = 2'b01;

  // Prediction attached to a fetch address
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic                   taken;
    logic [`FETCH_XLEN-1:0] target;
  } prediction_t;

  // Outcome of a branch from the branch unit
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] target;
    logic                   taken;
    logic                   mispredict;
  } resolution_t;

  // Word returned by instruction memory
  typedef struct packed {
    logic [`FETCH_ILEN-1:0] instr;
    logic                   except_raised;
    except_code_t           except_code;
  } mem_resp_t;

endpackage

`default_nettype wire

/* src/fetch_req_if.sv */
// Fetch request link from PC generator and predictor to the memory interface
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

interface fetch_req_if;

  // Handshake
  logic                   valid;
  logic                   ready;

  // Current fetch address
  logic [`FETCH_XLEN-1:0] pc;

  // Prediction for that address, same cycle
  fetch_pkg::prediction_t pred;

  modport pcgen (output valid, output pc, input ready);
  modport bpu   (output pred, input pc);
  modport memif (input valid, input pc, input pred, output ready);

endinterface

`default_nettype wire

/* src/fetch_stage.sv */
// Instruction fetch stage top: predictor, PC generator and memory interface
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    flush_i,
  input  logic                    flush_bpu_i,

  // Instruction memory
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output logic [`FETCH_XLEN-1:0]  instr_addr_o,
  input  logic                    instr_valid_i,
  output logic                    instr_ready_o,
  input  logic [`FETCH_ILEN-1:0]  instr_rdata_i,
  input  logic                    instr_except_raised_i,
  input  fetch_pkg::except_code_t instr_except_code_i,

  // Decode
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i,
  output logic [`FETCH_ILEN-1:0]  issue_instr_o,
  output fetch_pkg::prediction_t  issue_pred_o,
  output logic                    issue_except_raised_o,
  output fetch_pkg::except_code_t issue_except_code_o,

  // Branch unit
  output logic                    bu_pcgen_ready_o,
  input  logic                    bu_bpu_valid_i,
  input  logic                    bu_pcgen_valid_i,
  input  fetch_pkg::resolution_t  bu_res_i,

  // Commit
  input  logic                    comm_except_raised_i,
  input  logic [`FETCH_XLEN-1:0]  comm_except_pc_i
);

  // Shared current PC and its prediction
  fetch_req_if u_req_if ();

  // --------------------------------------------------
  // Predictor and PC generator share one PC
  // --------------------------------------------------
  bpu u_bpu (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flush_i    (flush_bpu_i),
    .req        (u_req_if.bpu),
    .res_valid_i(bu_bpu_valid_i),
    .res_i      (bu_res_i)
  );

  pc_gen u_pc_gen (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req             (u_req_if.pcgen),
    .pred_i          (u_req_if.pred),
    .comm_except_i   (comm_except_raised_i),
    .comm_except_pc_i(comm_except_pc_i),
    .res_valid_i     (bu_pcgen_valid_i),
    .res_i           (bu_res_i),
    .bu_ready_o      (bu_pcgen_ready_o)
  );

  // --------------------------------------------------
  // Memory interface toward memory and decode
  // --------------------------------------------------
  fetch_mem_if u_mem_if (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .flush_i              (flush_i),
    .req                  (u_req_if.memif),
    .instr_valid_o        (instr_valid_o),
    .instr_ready_i        (instr_ready_i),
    .instr_addr_o         (instr_addr_o),
    .instr_valid_i        (instr_valid_i),
    .instr_ready_o        (instr_ready_o),
    .instr_rdata_i        (instr_rdata_i),
    .instr_except_raised_i(instr_except_raised_i),
    .instr_except_code_i  (instr_except_code_i),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready_i),
    .issue_instr_o        (issue_instr_o),
    .issue_pred_o         (issue_pred_o),
    .issue_except_raised_o(issue_except_raised_o),
    .issue_except_code_o  (issue_except_code_o)
  );

endmodule

`default_nettype wire

/* src/pc_gen.sv */
// PC generator: program counter register and prioritized next-address select
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module pc_gen (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  fetch_req_if.pcgen             req,
  input  fetch_pkg::prediction_t pred_i,
  input  logic                   comm_except_i,
  input  logic [`FETCH_XLEN-1:0] comm_except_pc_i,
  input  logic                   res_valid_i,
  input  fetch_pkg::resolution_t res_i,
  output logic                   bu_ready_o
);

  localparam int unsigned XLEN = `FETCH_XLEN;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;
  logic            run_q;

  // --------------------------------------------------
  // Next PC, fixed priority
  // --------------------------------------------------
  always_comb begin
    pc_next = pc_q;
    if (comm_except_i) begin
      pc_next = comm_except_pc_i;
    end else if (res_valid_i && bu_ready_o && res_i.mispredict) begin
      // Wrong path, restart at the real outcome
      pc_next = res_i.taken ? res_i.target : res_i.pc + XLEN'(4);
    end else if (req.valid && req.ready) begin
      pc_next = pred_i.taken ? pred_i.target : pc_q + XLEN'(4);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q  <= `FETCH_BOOT_PC;
      run_q <= 1'b0;
    end else begin
      pc_q  <= pc_next;
      // Set on the first edge after reset
      run_q <= 1'b1;
    end
  end

  assign req.valid  = run_q;
  assign req.pc     = pc_q;
  assign bu_ready_o = run_q;

  // Redirect sources and predictor targets keep the PC on word boundaries
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* test/tb_fetch_stage.sv */
// Table-driven fetch stage testbench with memory and prediction models
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module tb_fetch_stage;

  localparam int unsigned XLEN          = `FETCH_XLEN;
  localparam int unsigned BTB_N         = 1 << `FETCH_BTB_BITS;
  localparam int unsigned POOL_N        = 256;
  localparam int unsigned MAX_ROWS      = 16;
  localparam int unsigned CYC_PER_FETCH = 20;
  localparam logic [31:0] MEM_XOR       = 32'hA5C3_0F96;

  typedef enum int {ACT_RUN, ACT_RESOLVE, ACT_EXCEPT, ACT_FLUSH_BPU, ACT_FAULT} action_e;

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic                    clk;
  logic                    arst_n;
  logic                    flush;
  logic                    flush_bpu;
  logic                    instr_valid_o;
  logic                    instr_ready;
  logic [XLEN-1:0]         instr_addr_o;
  logic                    mem_valid;
  logic                    instr_ready_o;
  logic [31:0]             mem_rdata;
  logic                    mem_exc;
  fetch_pkg::except_code_t mem_code;
  logic                    issue_valid_o;
  logic                    issue_ready;
  logic [31:0]             issue_instr_o;
  fetch_pkg::prediction_t  issue_pred_o;
  logic                    issue_exc_o;
  fetch_pkg::except_code_t issue_code_o;
  logic                    bu_pcgen_ready_o;
  logic                    bu_bpu_valid;
  logic                    bu_pcgen_valid;
  fetch_pkg::resolution_t  bu_res;
  logic                    comm_exc;
  logic [XLEN-1:0]         comm_exc_pc;

  // Test state
  logic            hold_issue;
  logic            rand_mode;
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] fault_addr;
  int              accepted = 0;
  int              issued   = 0;
  int              n_checks = 0;
  int              n_errors = 0;
  int              cyc      = 0;
  string           cur_name = "init";

  // Random pools filled from the seeded main process
  int   lat_pool [POOL_N];
  logic rdy_pool [POOL_N];
  int   lat_idx = 0;
  int   rdy_idx = 0;

  // Memory requests in flight
  logic [XLEN-1:0] mem_addr_q  [$];
  int              mem_due_q   [$];
  logic            mem_fault_q [$];

  // Reference BTB
  logic            ref_valid [BTB_N];
  logic [XLEN-1:0] ref_pc    [BTB_N];
  logic [XLEN-1:0] ref_tgt   [BTB_N];
  logic [1:0]      ref_cnt   [BTB_N];

  // Row table
  string           row_name  [MAX_ROWS];
  action_e         row_act   [MAX_ROWS];
  logic [XLEN-1:0] row_a     [MAX_ROWS];
  logic [XLEN-1:0] row_b     [MAX_ROWS];
  logic            row_taken [MAX_ROWS];
  logic            row_mis   [MAX_ROWS];
  logic            row_rnd   [MAX_ROWS];
  int              n_rows = 0;

  fetch_stage i_dut (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .flush_i              (flush),
    .flush_bpu_i          (flush_bpu),
    .instr_valid_o        (instr_valid_o),
    .instr_ready_i        (instr_ready),
    .instr_addr_o         (instr_addr_o),
    .instr_valid_i        (mem_valid),
    .instr_ready_o        (instr_ready_o),
    .instr_rdata_i        (mem_rdata),
    .instr_except_raised_i(mem_exc),
    .instr_except_code_i  (mem_code),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready),
    .issue_instr_o        (issue_instr_o),
    .issue_pred_o         (issue_pred_o),
    .issue_except_raised_o(issue_exc_o),
    .issue_except_code_o  (issue_code_o),
    .bu_pcgen_ready_o     (bu_pcgen_ready_o),
    .bu_bpu_valid_i       (bu_bpu_valid),
    .bu_pcgen_valid_i     (bu_pcgen_valid),
    .bu_res_i             (bu_res),
    .comm_except_raised_i (comm_exc),
    .comm_except_pc_i     (comm_exc_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference models
  // --------------------------------------------------
  // Memory contents as a function of the address
  function automatic logic [31:0] mem_word(input logic [XLEN-1:0] addr);
    return addr ^ MEM_XOR;
  endfunction

  function automatic int btb_index(input logic [XLEN-1:0] pc);
    return int'((pc >> 2) % BTB_N);
  endfunction

  // Hit with counter 2 or 3
  function automatic logic ref_taken(input logic [XLEN-1:0] pc);
    int i;
    i = btb_index(pc);
    return ref_valid[i] && (ref_pc[i] == pc) && (ref_cnt[i] >= 2'd2);
  endfunction

  task automatic ref_clear();
    for (int i = 0; i < BTB_N; i++) begin
      ref_valid[i] = 1'b0;
    end
  endtask

  task automatic ref_update(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                            input logic taken);
    int         i;
    logic [1:0] cnt;
    i   = btb_index(pc);
    // Miss starts from the empty-entry value
    cnt = (ref_valid[i] && ref_pc[i] == pc) ? ref_cnt[i] : fetch_pkg::BTB_INIT_CNT;
    if (taken) begin
      if (cnt != 2'd3) cnt = cnt + 2'd1;
      ref_tgt[i] = tgt;
    end else if (cnt != 2'd0) begin
      cnt = cnt - 2'd1;
    end
    ref_valid[i] = 1'b1;
    ref_pc[i]    = pc;
    ref_cnt[i]   = cnt;
  endtask

  // --------------------------------------------------
  // Checking
  // --------------------------------------------------
  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error %s/%s: expected %08h, actual %08h", cur_name, what, exp, act);
    end
  endtask

  // One issued instruction against the expected stream
  task automatic check_issue();
    logic            exp_tk;
    logic [XLEN-1:0] exp_tgt;
    logic            exp_fault;
    exp_tk    = ref_taken(exp_pc);
    exp_tgt   = exp_tk ? ref_tgt[btb_index(exp_pc)] : exp_pc + 32'd4;
    exp_fault = (exp_pc == fault_addr);
    check_val("pc", exp_pc, issue_pred_o.pc);
    check_val("instr", mem_word(exp_pc), issue_instr_o);
    check_val("taken", exp_tk, issue_pred_o.taken);
    check_val("target", exp_tgt, issue_pred_o.target);
    check_val("except", exp_fault, issue_exc_o);
    check_val("code", exp_fault ? fetch_pkg::E_INSTR_ACCESS_FAULT : 4'h0, issue_code_o);
    // Next PC follows the prediction
    exp_pc = exp_tgt;
    issued++;
  endtask

  // Handshakes sampled at the falling edge where all signals are stable
  initial begin : sample
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (mem_valid && instr_ready_o) begin
          void'(mem_addr_q.pop_front());
          void'(mem_due_q.pop_front());
          void'(mem_fault_q.pop_front());
        end
        if (instr_valid_o && instr_ready) begin
          mem_addr_q.push_back(instr_addr_o);
          mem_due_q.push_back(cyc + 1 + lat_pool[lat_idx]);
          mem_fault_q.push_back(instr_addr_o == fault_addr);
          lat_idx = (lat_idx + 1) % POOL_N;
          accepted++;
        end
        if (issue_valid_o && issue_ready) check_issue();
      end
    end
  end

  // --------------------------------------------------
  // In-order memory model with variable latency
  // --------------------------------------------------
  initial begin : mem_respond
    mem_valid = 1'b0;
    mem_rdata = '0;
    mem_exc   = 1'b0;
    mem_code  = '0;
    forever begin
      @(posedge clk);
      cyc++;
      #1;
      // Front word held until memory sees it taken
      if (mem_addr_q.size() != 0 && mem_due_q[0] <= cyc) begin
        mem_valid = 1'b1;
        mem_rdata = mem_word(mem_addr_q[0]);
        mem_exc   = mem_fault_q[0];
        mem_code  = mem_fault_q[0] ? fetch_pkg::E_INSTR_ACCESS_FAULT : 4'h0;
      end else begin
        mem_valid = 1'b0;
        mem_exc   = 1'b0;
        mem_code  = '0;
      end
    end
  end

  // Decode back-pressure
  initial begin : issue_drive
    logic nxt;
    issue_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (!arst_n || hold_issue) begin
        nxt = 1'b0;
      end else if (rand_mode) begin
        nxt     = rdy_pool[rdy_idx];
        rdy_idx = (rdy_idx + 1) % POOL_N;
      end else begin
        nxt = 1'b1;
      end
      #1 issue_ready = nxt;
    end
  end

  // --------------------------------------------------
  // Row actions
  // --------------------------------------------------
  task automatic add_row(input string name, input action_e act, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic tk, input logic mis,
                         input logic rnd);
    row_name[n_rows]  = name;
    row_act[n_rows]   = act;
    row_a[n_rows]     = a;
    row_b[n_rows]     = b;
    row_taken[n_rows] = tk;
    row_mis[n_rows]   = mis;
    row_rnd[n_rows]   = rnd;
    n_rows++;
  endtask

  task automatic load_table();
    add_row("boot_seq",   ACT_RUN,       8,        0,        0, 0, 0);
    add_row("train",      ACT_RESOLVE,   32'h1008, 32'h1100, 1, 0, 0);
    add_row("restart_a",  ACT_EXCEPT,    32'h1000, 0,        0, 0, 0);
    add_row("btb_hit",    ACT_RUN,       4,        0,        0, 0, 0);
    add_row("flush_btb",  ACT_FLUSH_BPU, 0,        0,        0, 0, 0);
    add_row("restart_b",  ACT_EXCEPT,    32'h1000, 0,        0, 0, 0);
    add_row("btb_miss",   ACT_RUN,       4,        0,        0, 0, 0);
    add_row("mispredict", ACT_RESOLVE,   32'h100c, 32'h2000, 1, 1, 0);
    add_row("new_path",   ACT_RUN,       6,        0,        0, 0, 0);
    add_row("set_fault",  ACT_FAULT,     32'h3008, 0,        0, 0, 0);
    add_row("jump_3000",  ACT_EXCEPT,    32'h3000, 0,        0, 0, 0);
    add_row("random_run", ACT_RUN,       24,       0,        0, 0, 1);
  endtask

  function automatic int total_fetches();
    int sum;
    sum = 0;
    for (int r = 0; r < n_rows; r++) begin
      if (row_act[r] == ACT_RUN) sum += int'(row_a[r]);
    end
    return sum;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Exactly n requests reach memory and then all n reach decode
  task automatic run_fetches(input int n, input logic rnd);
    int acc_goal;
    int iss_goal;
    acc_goal  = accepted + n;
    iss_goal  = issued + n;
    rand_mode = rnd;
    do begin
      next_cycle();
      instr_ready = (accepted < acc_goal);
    end while (accepted < acc_goal);
    while (issued < iss_goal) next_cycle();
    rand_mode = 1'b0;
  endtask

  task automatic drive_res(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                           input logic tk, input logic mis);
    bu_res.pc         = pc;
    bu_res.target     = tgt;
    bu_res.taken      = tk;
    bu_res.mispredict = mis;
    bu_bpu_valid      = 1'b1;
    bu_pcgen_valid    = 1'b1;
    check_val("bu ready", 1, bu_pcgen_ready_o);
    ref_update(pc, tgt, tk);
  endtask

  task automatic resolve_branch(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                                input logic tk);
    next_cycle();
    drive_res(pc, tgt, tk, 1'b0);
    next_cycle();
    bu_bpu_valid   = 1'b0;
    bu_pcgen_valid = 1'b0;
  endtask

  task automatic resolve_mispredict(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                                    input logic tk);
    // Wrong path in flight and kept away from decode
    next_cycle();
    hold_issue  = 1'b1;
    instr_ready = 1'b1;
    repeat (3) next_cycle();
    instr_ready = 1'b0;
    flush       = 1'b1;
    drive_res(pc, tgt, tk, 1'b1);
    exp_pc = tk ? tgt : pc + 32'd4;
    next_cycle();
    flush          = 1'b0;
    bu_bpu_valid   = 1'b0;
    bu_pcgen_valid = 1'b0;
    hold_issue     = 1'b0;
    // Late words of the old path are owed and dropped
    while (mem_addr_q.size() != 0) next_cycle();
    repeat (2) next_cycle();
    check_val("old path issued", 0, issue_valid_o);
  endtask

  task automatic commit_exception(input logic [XLEN-1:0] addr);
    next_cycle();
    comm_exc    = 1'b1;
    comm_exc_pc = addr;
    flush       = 1'b1;
    exp_pc      = addr;
    next_cycle();
    comm_exc = 1'b0;
    flush    = 1'b0;
  endtask

  task automatic flush_predictor();
    next_cycle();
    flush_bpu = 1'b1;
    ref_clear();
    next_cycle();
    flush_bpu = 1'b0;
  endtask

  task automatic apply_row(input int r);
    cur_name = row_name[r];
    case (row_act[r])
      ACT_RUN:       run_fetches(int'(row_a[r]), row_rnd[r]);
      ACT_RESOLVE: begin
        if (row_mis[r]) resolve_mispredict(row_a[r], row_b[r], row_taken[r]);
        else            resolve_branch(row_a[r], row_b[r], row_taken[r]);
      end
      ACT_EXCEPT:    commit_exception(row_a[r]);
      ACT_FLUSH_BPU: flush_predictor();
      ACT_FAULT:     fault_addr = row_a[r];
      default: begin
        n_errors++;
        $display("error %s: unknown action in table", cur_name);
      end
    endcase
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main
    void'($urandom(47));
    for (int i = 0; i < POOL_N; i++) begin
      lat_pool[i] = $urandom_range(3, 0);
      rdy_pool[i] = ($urandom_range(3, 0) != 0);
    end
    arst_n         = 1'b0;
    flush          = 1'b0;
    flush_bpu      = 1'b0;
    instr_ready    = 1'b0;
    bu_bpu_valid   = 1'b0;
    bu_pcgen_valid = 1'b0;
    bu_res         = '0;
    comm_exc       = 1'b0;
    comm_exc_pc    = '0;
    hold_issue     = 1'b0;
    rand_mode      = 1'b0;
    fault_addr     = 32'hFFFF_FFFC;
    exp_pc         = `FETCH_BOOT_PC;
    load_table();
    ref_clear();

    repeat (5) @(posedge clk);
    cur_name = "reset";
    check_val("instr valid", 0, instr_valid_o);
    check_val("issue valid", 0, issue_valid_o);
    check_val("instr ready", 1, instr_ready_o);
    check_val("bu ready", 0, bu_pcgen_ready_o);
    #1 arst_n = 1'b1;

    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
    end

    repeat (4) next_cycle();
    cur_name = "end";
    check_val("issued count", total_fetches(), issued);
    $display("checks: %0d, errors: %0d, issued: %0d", n_checks, n_errors, issued);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Run limit scales with the table's fetch count
  initial begin : watchdog
    int limit;
    wait (arst_n === 1'b1);
    limit = total_fetches() * CYC_PER_FETCH;
    repeat (limit) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles after reset", limit);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
